// ==== source/drive_if.sv ====
/*
 * drive_if, one drive's motor trigger, select level and mechanics status
 */
`timescale 1ns/10ps

interface drive_if;

   logic motor_trig;    // 1-cycle pulse from command block
   logic selected;      // drive picked by drv_sel
   logic motor_on;      // spindle running
   logic spin_up_done;  // spindle at speed
   logic index_pulse;   // once per rotation

   // command block side, one trigger for all drives
   modport ctrl (
      output motor_trig
   );

   // drive mechanics side
   modport mech (
      input  motor_trig,
      input  selected,
      output motor_on,
      output spin_up_done,
      output index_pulse
   );

   // status pick-up
   modport mon (
      input motor_on,
      input spin_up_done,
      input index_pulse
   );

endinterface : drive_if

// ==== source/drive_status_mux.sv ====
/*
 * drive status mux, forwards the selected drive's mechanics status
 * and serves the io controller status byte
 */
`timescale 1ns/10ps

module drive_status_mux (
   input  logic [fdc_pkg::NUM_DRIVES-1:0] drv_sel,   // active low
   input  logic                           drv_side,
   input  fdc_pkg::status_sel_t           status_sel,
   input  fdc_pkg::fdc_byte_t             cmd_reg,
   input  fdc_pkg::fdc_byte_t             track_reg,
   input  fdc_pkg::fdc_byte_t             sector_reg,
   input  fdc_pkg::fdc_byte_t             data_reg,
   input  logic                           io_waiting,
   output logic                           sel_motor_on,
   output logic                           sel_spin_up_done,
   output logic                           sel_index,
   output fdc_pkg::fdc_byte_t             status_byte,
   drive_if.mon                           mon [fdc_pkg::NUM_DRIVES]
);
   import fdc_pkg::*;

   logic [NUM_DRIVES-1:0] sel_hot;   // active high select
   logic [NUM_DRIVES-1:0] mon_on;
   logic [NUM_DRIVES-1:0] mon_spun;
   logic [NUM_DRIVES-1:0] mon_idx;
   logic                  one_sel;   // exactly one drive picked

   // flatten interface array so it can be masked
   for (genvar i = 0; i < NUM_DRIVES; i++) begin : g_mon
      assign mon_on[i]   = mon[i].motor_on;
      assign mon_spun[i] = mon[i].spin_up_done;
      assign mon_idx[i]  = mon[i].index_pulse;
   end

   assign sel_hot = ~drv_sel;
   assign one_sel = (sel_hot != '0) && ((sel_hot & (sel_hot - 1'b1)) == '0);

   assign sel_motor_on     = one_sel && |(mon_on & sel_hot);
   assign sel_spin_up_done = one_sel && |(mon_spun & sel_hot);
   assign sel_index        = one_sel && |(mon_idx & sel_hot);

   always_comb begin
      case (status_sel)
         3'd0:    status_byte = cmd_reg;
         3'd1:    status_byte = track_reg;
         3'd2:    status_byte = sector_reg;
         3'd3:    status_byte = data_reg;
         3'd4:    status_byte = fdc_byte_t'({drv_sel, drv_side, io_waiting});
         default: status_byte = '0;
      endcase
   end

endmodule : drive_status_mux

// ==== source/fdc_cmd_regs.sv ====
/*
 * wd1772 style register block, command decode, busy FSM and irq
 * type I runs a delay, type II/III wait for the io controller
 */
`timescale 1ns/10ps

module fdc_cmd_regs #(
   parameter fdc_pkg::timer_t RESTORE_DLY = 32'd2_000_000,
   parameter fdc_pkg::timer_t SEEK_DLY    = 32'd200_000,
   parameter fdc_pkg::timer_t STEP_DLY    = 32'd20_000
) (
   input  logic               clk,
   input  logic               motor_start,       // async reset
   // cpu side
   input  fdc_pkg::reg_addr_t cpu_addr,
   input  logic               cpu_sel,
   input  logic               cpu_rw,            // 1 read, 0 write
   input  fdc_pkg::fdc_byte_t cpu_din,
   output fdc_pkg::fdc_byte_t cpu_dout,
   output logic               irq,
   // drive and io controller
   input  logic               wr_prot,
   input  logic               dma_ack,
   input  logic               sel_motor_on,
   input  logic               sel_spin_up_done,
   input  logic               sel_index,
   // register view for the io side
   output fdc_pkg::fdc_byte_t cmd_reg,
   output fdc_pkg::fdc_byte_t track_reg,
   output fdc_pkg::fdc_byte_t sector_reg,
   output fdc_pkg::fdc_byte_t data_reg,
   output logic               io_waiting,
   drive_if.ctrl              drv [fdc_pkg::NUM_DRIVES]
);
   import fdc_pkg::*;

   busy_state_t state;
   timer_t      delay_cnt;   // int_wait countdown
   logic        step_dir;    // 1 = in, remembered for plain step
   logic        motor_trig;
   logic        cmd_wr;      // command register write this cycle
   logic        mtr_req;     // type I or II written
   logic        type1;       // last command was type I
   logic        busy;
   fdc_byte_t   status;

   assign cmd_wr  = cpu_sel && !cpu_rw && (cpu_addr == 2'd0);
   assign mtr_req = cmd_wr && (!cpu_din[7] || (cpu_din[7:6] == 2'b10));

   assign type1      = !cmd_reg[7];
   assign busy       = (state != st_idle);
   assign io_waiting = (state == st_io_wait);

   // same trigger to every drive, each one checks its own select
   for (genvar i = 0; i < NUM_DRIVES; i++) begin : g_trig
      assign drv[i].motor_trig = motor_trig;
   end

   // status register as the cpu reads it
   assign status = {
      sel_motor_on,
      wr_prot,
      type1 ? sel_spin_up_done : 1'b0,
      2'b00,                              // rnf / crc never set
      type1 ? (track_reg == 8'd0) : 1'b0, // track 0
      type1 ? sel_index : busy,           // index or drq
      busy
   };

   // combinational read, zero when not selected
   always_comb begin
      cpu_dout = '0;
      if (cpu_sel && cpu_rw) begin
         case (cpu_addr)
            2'd0:    cpu_dout = status;
            2'd1:    cpu_dout = track_reg;
            2'd2:    cpu_dout = sector_reg;
            default: cpu_dout = data_reg;
         endcase
      end
   end

   always_ff @(posedge clk or posedge motor_start) begin
      if (motor_start) begin
         cmd_reg    <= '0;
         track_reg  <= '0;
         sector_reg <= '0;
         data_reg   <= '0;
         state      <= st_idle;
         delay_cnt  <= '0;
         step_dir   <= 1'b0;
         irq        <= 1'b0;
         motor_trig <= 1'b0;
      end else begin
         motor_trig <= mtr_req;  // drives load on the next edge

         case (state)
            st_int_wait: begin
               if (delay_cnt != '0)
                  delay_cnt <= delay_cnt - 1'b1;
               else
                  state <= st_irq;
            end
            st_io_wait: if (dma_ack) state <= st_irq;
            st_irq: begin
               irq   <= 1'b1;
               state <= st_idle;
            end
            default: ;
         endcase

         // any access to address 0 acks the interrupt, wins over the set above
         if (cpu_sel && (cpu_addr == 2'd0))
            irq <= 1'b0;

         if (cpu_sel && !cpu_rw) begin
            case (cpu_addr)
               2'd0: begin
                  cmd_reg   <= cpu_din;
                  state     <= st_int_wait;  // default, delay 0
                  delay_cnt <= '0;
                  casez (cpu_din[7:4])
                     4'b0000: begin                 // restore
                        track_reg <= '0;
                        delay_cnt <= RESTORE_DLY;
                     end
                     4'b0001: begin                 // seek
                        track_reg <= data_reg;
                        delay_cnt <= SEEK_DLY;
                     end
                     4'b001?: begin                 // step, last direction
                        delay_cnt <= STEP_DLY;
                        if (cpu_din[4])
                           track_reg <= step_dir ? track_reg + 8'd1 : track_reg - 8'd1;
                     end
                     4'b010?: begin                 // step in
                        delay_cnt <= STEP_DLY;
                        step_dir  <= 1'b1;
                        if (cpu_din[4]) track_reg <= track_reg + 8'd1;
                     end
                     4'b011?: begin                 // step out
                        delay_cnt <= STEP_DLY;
                        step_dir  <= 1'b0;
                        if (cpu_din[4]) track_reg <= track_reg - 8'd1;
                     end
                     4'b100?: state <= st_io_wait;  // read sector
                     4'b101?: if (!wr_prot) state <= st_io_wait;  // write sector
                     4'b1100: state <= st_io_wait;  // read address
                     4'b1110: state <= st_io_wait;  // read track
                     4'b1111: if (!wr_prot) state <= st_io_wait;  // write track
                     default: begin                 // 1101 force interrupt
                        if (cpu_din[3:0] == 4'h0)
                           state <= st_idle;        // quiet abort
                        else
                           state <= st_irq;
                     end
                  endcase
               end
               2'd1:    track_reg  <= cpu_din;
               2'd2:    sector_reg <= cpu_din;
               default: data_reg   <= cpu_din;
            endcase
         end
      end
   end

   // irq comes up only on the way back to idle, a new command acks it
   a_no_irq_while_waiting : assert property (
      @(posedge clk) disable iff (motor_start)
      $rose(irq) |-> !(state inside {st_int_wait, st_io_wait})
   ) else $error("irq rose while fdc still waiting");

   // one trigger pulse per command write
   a_trig_one_cycle : assert property (
      @(posedge clk) disable iff (motor_start)
      motor_trig |=> !motor_trig
   ) else $error("motor trigger longer than one cycle");

endmodule : fdc_cmd_regs

// ==== source/fdc_pkg.sv ====
/*
 * fdc shared types, the widths, busy state encoding and drive count
 */
package fdc_pkg;

   // number of emulated drives, one per drv_sel bit (active low)
   localparam int NUM_DRIVES = 2;

   // register and bus byte
   typedef logic [7:0] fdc_byte_t;

   // cpu register address
   // 0 command on write, status on read
   // 1 track
   // 2 sector
   // 3 data
   typedef logic [1:0] reg_addr_t;

   // selects which byte the io controller sees on status_byte
   typedef logic [2:0] status_sel_t;

   // motor run, index and step delay counters
   typedef logic [31:0] timer_t;

   // busy state machine of the command block
   typedef enum logic [1:0] {
      st_idle     = 2'd0,  // nothing pending
      st_irq      = 2'd1,  // end of busy phase, raise irq next
      st_int_wait = 2'd2,  // internal delay running (seek, step...)
      st_io_wait  = 2'd3   // waiting for io controller dma_ack
   } busy_state_t;

endpackage : fdc_pkg

// ==== source/fdc_top.sv ====
/*
 * fdc top, register block plus generated drive models and status mux
 */
`timescale 1ns/10ps

module fdc_top #(
   parameter fdc_pkg::timer_t MOTOR_RUN    = 32'd16_000_000,
   parameter fdc_pkg::timer_t MOTOR_SPINUP = 32'd8_000_000,
   parameter fdc_pkg::timer_t INDEX_PERIOD = 32'd1_600_000,
   parameter fdc_pkg::timer_t INDEX_WIDTH  = 32'd100_000,
   parameter fdc_pkg::timer_t RESTORE_DLY  = 32'd2_000_000,
   parameter fdc_pkg::timer_t SEEK_DLY     = 32'd200_000,
   parameter fdc_pkg::timer_t STEP_DLY     = 32'd20_000
) (
   input  logic                           clk,
   input  logic                           motor_start,
   input  logic [fdc_pkg::NUM_DRIVES-1:0] drv_sel,
   input  logic                           drv_side,
   input  logic                           wr_prot,
   input  logic                           dma_ack,
   input  fdc_pkg::status_sel_t           status_sel,
   output fdc_pkg::fdc_byte_t             status_byte,
   input  fdc_pkg::reg_addr_t             cpu_addr,
   input  logic                           cpu_sel,
   input  logic                           cpu_rw,
   input  fdc_pkg::fdc_byte_t             cpu_din,
   output fdc_pkg::fdc_byte_t             cpu_dout,
   output logic                           irq
);
   import fdc_pkg::*;

   fdc_byte_t cmd_reg, track_reg, sector_reg, data_reg;
   logic      io_waiting;
   logic      sel_motor_on, sel_spin_up_done, sel_index;

   drive_if drv_bus [NUM_DRIVES] ();

   fdc_cmd_regs #(
      .RESTORE_DLY(RESTORE_DLY), .SEEK_DLY(SEEK_DLY), .STEP_DLY(STEP_DLY)
   ) regs_i (
      .clk, .motor_start, .cpu_addr, .cpu_sel, .cpu_rw, .cpu_din, .cpu_dout, .irq,
      .wr_prot, .dma_ack, .sel_motor_on, .sel_spin_up_done, .sel_index,
      .cmd_reg, .track_reg, .sector_reg, .data_reg, .io_waiting, .drv(drv_bus)
   );

   for (genvar i = 0; i < NUM_DRIVES; i++) begin : g_drive
      assign drv_bus[i].selected = ~drv_sel[i];  // select line is active low
      floppy_drive #(
         .MOTOR_RUN(MOTOR_RUN), .MOTOR_SPINUP(MOTOR_SPINUP),
         .INDEX_PERIOD(INDEX_PERIOD), .INDEX_WIDTH(INDEX_WIDTH)
      ) drive_i (
         .clk, .motor_start, .mech(drv_bus[i])
      );
   end

   drive_status_mux mux_i (
      .drv_sel, .drv_side, .status_sel, .cmd_reg, .track_reg, .sector_reg, .data_reg,
      .io_waiting, .sel_motor_on, .sel_spin_up_done, .sel_index, .status_byte,
      .mon(drv_bus)
   );

endmodule : fdc_top

// ==== source/floppy_drive.sv ====
/*
 * drive mechanics model, spindle run-down timer, spin-up flag, index pulse
 */
`timescale 1ns/10ps

module floppy_drive #(
   parameter fdc_pkg::timer_t MOTOR_RUN    = 32'd16_000_000,
   parameter fdc_pkg::timer_t MOTOR_SPINUP = 32'd8_000_000,
   parameter fdc_pkg::timer_t INDEX_PERIOD = 32'd1_600_000,
   parameter fdc_pkg::timer_t INDEX_WIDTH  = 32'd100_000
) (
   input  logic  clk,
   input  logic  motor_start,   // async reset
   drive_if.mech mech
);
   import fdc_pkg::*;

   timer_t motor_cnt;
   timer_t motor_nxt;
   timer_t index_cnt;
   logic   motor_on;

   assign motor_on = (motor_cnt != '0);

   // retrigger only when this drive is selected, cold start adds spin-up
   always_comb begin
      motor_nxt = motor_cnt;
      if (mech.motor_trig && mech.selected)
         motor_nxt = motor_on ? MOTOR_RUN : MOTOR_RUN + MOTOR_SPINUP;
      else if (motor_on)
         motor_nxt = motor_cnt - 1'b1;  // run down
   end

   always_ff @(posedge clk or posedge motor_start) begin
      if (motor_start) begin
         motor_cnt <= '0;
         index_cnt <= '0;
      end else begin
         motor_cnt <= motor_nxt;
         // index counter follows next motor state, both stop together
         if (motor_nxt == '0)
            index_cnt <= '0;
         else if (index_cnt == '0)
            index_cnt <= INDEX_PERIOD;  // one rotation
         else
            index_cnt <= index_cnt - 1'b1;
      end
   end

   assign mech.motor_on     = motor_on;
   assign mech.spin_up_done = motor_on && (motor_cnt <= MOTOR_RUN);
   assign mech.index_pulse  = (index_cnt > INDEX_PERIOD - INDEX_WIDTH);  // top of count

   a_index_needs_motor : assert property (
      @(posedge clk) disable iff (motor_start)
      mech.index_pulse |-> mech.motor_on
   ) else $error("index pulse with motor off");

endmodule : floppy_drive

// ==== src.f ====
source/fdc_pkg.sv
source/drive_if.sv
source/fdc_cmd_regs.sv
source/floppy_drive.sv
source/drive_status_mux.sv
source/fdc_top.sv
test/tb_clock_gen.sv
test/fdc_tb.sv

// ==== test/fdc_tb.sv ====
/*
 * fdc testbench, LFSR driven commands and register traffic
 * checked every cycle against a behavioral model of regs, busy timing and drives
 */
`timescale 1ns/10ps

module fdc_tb;
   import fdc_pkg::*;

   localparam int MOTOR_RUN    = 200;
   localparam int MOTOR_SPINUP = 100;
   localparam int INDEX_PERIOD = 40;
   localparam int INDEX_WIDTH  = 8;
   localparam int RESTORE_DLY  = 30;
   localparam int SEEK_DLY     = 20;
   localparam int STEP_DLY     = 10;
   localparam int N_CMDS       = 60;
   localparam int WAIT_LIMIT   = RESTORE_DLY + 64;   // longest busy phase plus ack delay
   localparam int CMD_WORST    = MOTOR_RUN + MOTOR_SPINUP + WAIT_LIMIT;
   localparam int CYCLE_LIMIT  = (N_CMDS + 2) * CMD_WORST + 500;

   logic                  clk, motor_start;
   logic [NUM_DRIVES-1:0] drv_sel;                   // active low
   logic                  drv_side, wr_prot, dma_ack, cpu_sel, cpu_rw, irq;
   status_sel_t           status_sel;
   reg_addr_t             cpu_addr;
   fdc_byte_t             cpu_din, cpu_dout, status_byte;

   // reference state
   fdc_byte_t   m_cmd, m_track, m_sector, m_data;
   logic        m_dir, m_irq, m_io, m_trig;          // m_io = waiting for dma_ack
   int          m_cnt;                               // edges until irq, 0 none pending
   int          mcnt [NUM_DRIVES];                   // motor run-down count
   int          icnt [NUM_DRIVES];                   // index count
   logic [31:0] lfsr = 32'h20f18277;
   int          value_errs = 0;
   int          other_errs = 0;
   int          cycles = 0;
   fdc_byte_t   cmd_base [11] = '{8'h00, 8'h10, 8'h20, 8'h40, 8'h60, 8'h80,
                                  8'ha0, 8'hc0, 8'he0, 8'hf0, 8'hd0};

   tb_clock_gen clk_i (.clk, .motor_start);

   fdc_top #(
      .MOTOR_RUN(MOTOR_RUN), .MOTOR_SPINUP(MOTOR_SPINUP),
      .INDEX_PERIOD(INDEX_PERIOD), .INDEX_WIDTH(INDEX_WIDTH),
      .RESTORE_DLY(RESTORE_DLY), .SEEK_DLY(SEEK_DLY), .STEP_DLY(STEP_DLY)
   ) dut_i (.*);

   // galois lfsr, taps 32 22 2 1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return v;
   endfunction

   function automatic int picked_drive();
      case (drv_sel)
         2'b10:   return 0;
         2'b01:   return 1;
         default: return -1;     // none or both
      endcase
   endfunction

   function automatic logic model_busy();
      return (m_cnt != 0) || m_io;
   endfunction

   function automatic fdc_byte_t exp_cpu_status();
      int   d;
      logic t1, on, spun, idx;
      d    = picked_drive();
      t1   = !m_cmd[7];
      on   = 1'b0;
      spun = 1'b0;
      idx  = 1'b0;
      if (d >= 0) begin
         on   = mcnt[d] != 0;
         spun = on && (mcnt[d] <= MOTOR_RUN);
         idx  = icnt[d] > INDEX_PERIOD - INDEX_WIDTH;
      end
      return {on, wr_prot, t1 && spun, 2'b00, t1 && (m_track == 8'd0),
              t1 ? idx : model_busy(), model_busy()};
   endfunction

   function automatic fdc_byte_t exp_cpu_dout();
      if (!(cpu_sel && cpu_rw))
         return '0;
      case (cpu_addr)
         2'd0:    return exp_cpu_status();
         2'd1:    return m_track;
         2'd2:    return m_sector;
         default: return m_data;
      endcase
   endfunction

   function automatic fdc_byte_t exp_status_byte();
      case (status_sel)
         3'd0:    return m_cmd;
         3'd1:    return m_track;
         3'd2:    return m_sector;
         3'd3:    return m_data;
         3'd4:    return {4'b0000, drv_sel, drv_side, m_io};
         default: return '0;
      endcase
   endfunction

   // cpu write as seen by the reference
   task automatic model_write(input reg_addr_t a, input fdc_byte_t d);
      int dly;
      case (a)
         2'd1: m_track  = d;
         2'd2: m_sector = d;
         2'd3: m_data   = d;
         default: begin
            m_cmd = d;
            m_io  = 1'b0;
            m_cnt = 0;
            if (!d[7]) begin                          // type I
               dly = STEP_DLY;
               if (d[6:5] == 2'b00) begin
                  m_track = d[4] ? m_data : 8'd0;    // seek or restore
                  dly     = d[4] ? SEEK_DLY : RESTORE_DLY;
               end else begin
                  if (d[6])
                     m_dir = !d[5];                   // step in / out sets direction
                  if (d[4])
                     m_track = m_dir ? m_track + 8'd1 : m_track - 8'd1;
               end
               m_cnt = dly + 2;
            end else if (d[7:4] == 4'hd)
               m_cnt = (d[3:0] == 4'h0) ? 0 : 1;      // force interrupt
            else if (wr_prot && d[5] && (!d[6] || d[4]))
               m_cnt = 2;                             // protected write ends at once
            else
               m_io = 1'b1;
         end
      endcase
   endtask

   always @(posedge clk or posedge motor_start) begin
      int nxt;
      if (motor_start) begin
         {m_cmd, m_track, m_sector, m_data} = '0;
         {m_dir, m_irq, m_io, m_trig} = '0;
         m_cnt = 0;
         foreach (mcnt[i]) begin
            mcnt[i] = 0;
            icnt[i] = 0;
         end
      end else begin
         for (int i = 0; i < NUM_DRIVES; i++) begin
            nxt = mcnt[i];
            if (m_trig && !drv_sel[i])
               nxt = (mcnt[i] != 0) ? MOTOR_RUN : MOTOR_RUN + MOTOR_SPINUP;
            else if (nxt != 0)
               nxt = nxt - 1;
            icnt[i] = (nxt == 0) ? 0 : (icnt[i] == 0) ? INDEX_PERIOD : icnt[i] - 1;
            mcnt[i] = nxt;
         end
         m_trig = cpu_sel && !cpu_rw && (cpu_addr == 2'd0) &&
                  (cpu_din[7:6] != 2'b11);            // type I or II
         if (m_cnt != 0) begin
            m_cnt = m_cnt - 1;
            if (m_cnt == 0)
               m_irq = 1'b1;
         end
         if (m_io && dma_ack) begin
            m_io  = 1'b0;
            m_cnt = 1;
         end
         if (cpu_sel && (cpu_addr == 2'd0))
            m_irq = 1'b0;                             // status access acks
         if (cpu_sel && !cpu_rw)
            model_write(cpu_addr, cpu_din);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("timeout, test still running after %0d clock cycles", cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   task automatic check_val(input string name, input fdc_byte_t got, input fdc_byte_t exp);
      assert (got === exp) else begin
         $display("[FAIL] %0t %s got %02h expected %02h", $time, name, got, exp);
         value_errs++;
      end
   endtask

   // falling edge, compare outputs then drop the one-cycle inputs
   task automatic tick();
      @(negedge clk);
      check_val("cpu_dout", cpu_dout, exp_cpu_dout());
      check_val("irq", 8'(irq), 8'(m_irq));
      check_val("status_byte", status_byte, exp_status_byte());
      cpu_sel    = 1'b0;
      dma_ack    = 1'b0;
      status_sel = status_sel_t'(rand_bits(3));
      drv_side   = rand_bits(1);
   endtask

   task automatic cpu_access(input reg_addr_t a, input logic rw, input fdc_byte_t d);
      cpu_sel  = 1'b1;
      cpu_addr = a;
      cpu_rw   = rw;
      cpu_din  = d;
   endtask

   task automatic run_command(input fdc_byte_t cmd);
      int ack_cnt;
      int waited;
      ack_cnt = rand_bits(4);
      waited  = 0;
      tick();
      cpu_access(2'd0, 1'b0, cmd);
      if (cmd[7:4] != 4'hd && rand_bits(2) == 0) begin   // abort while busy
         repeat (1 + rand_bits(3)) tick();
         cpu_access(2'd0, 1'b0, {4'hd, rand_bits(1) ? 4'h0 : 4'(rand_bits(4))});
      end
      do begin
         tick();
         dma_ack = (ack_cnt == 0);   // single ack pulse, ignored unless io wait
         ack_cnt--;
         if (rand_bits(2) == 0)
            cpu_access(reg_addr_t'(1 + rand_bits(1) + rand_bits(1)), 1'b1, 8'h00);
         waited++;
      end while (irq !== 1'b1 && (model_busy() || m_irq) && waited < WAIT_LIMIT);
      assert (waited < WAIT_LIMIT) else begin
         $display("command %02h did not finish within %0d cycles", cmd, WAIT_LIMIT);
         other_errs++;
      end
      repeat (rand_bits(5)) begin
         tick();
         cpu_access(2'd0, 1'b1, 8'h00);    // status read, clears irq
      end
   endtask

   initial begin
      fdc_byte_t cmd;
      cpu_sel    = 1'b0;
      cpu_rw     = 1'b1;
      cpu_addr   = 2'd0;
      cpu_din    = 8'h00;
      drv_sel    = 2'b11;
      drv_side   = 1'b0;
      wr_prot    = 1'b0;
      dma_ack    = 1'b0;
      status_sel = 3'd0;
      wait (motor_start === 1'b0);

      for (int a = 1; a < 4; a++) begin        // track, sector, data
         tick();
         cpu_access(reg_addr_t'(a), 1'b0, rand_bits(8));
         tick();
         cpu_access(reg_addr_t'(a), 1'b1, 8'h00);
      end
      for (int s = 0; s < 8; s++) begin
         tick();
         status_sel = status_sel_t'(s);
      end

      repeat (N_CMDS) begin
         tick();
         drv_sel = rand_bits(2);
         wr_prot = rand_bits(1);
         cpu_access(2'd3, 1'b0, rand_bits(8));  // seek target
         cmd = cmd_base[rand_bits(4) % 11];
         if (cmd[7:5] inside {3'd1, 3'd2, 3'd3, 3'd4, 3'd5})
            cmd[4] = rand_bits(1);               // update or multi bit
         cmd[3:0] = (cmd[7:4] == 4'hd && rand_bits(1)) ? 4'h0 : 4'(rand_bits(4));
         run_command(cmd);
      end

      // cold start on drive 0, then watch the motor run down
      drv_sel = 2'b10;
      run_command(8'h00);
      repeat (MOTOR_RUN + MOTOR_SPINUP + 16) begin
         tick();
         cpu_access(2'd0, 1'b1, 8'h00);
      end
      tick();

      $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule : fdc_tb

// ==== test/tb_clock_gen.sv ====
/*
 * testbench clock and reset, 40 ns period, reset held for 10 cycles
 */
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter int HALF_PERIOD  = 20,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic motor_start
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial begin
      motor_start = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);       // release away from the rising edge
      motor_start = 1'b0;
   end

endmodule : tb_clock_gen
